// ==== hdl/demosaicPkg.sv ====
package demosaicPkg;

	// image geometry
	localparam int imageWidth = 16;
	localparam int imageHeight = 8;

	// one trailing padding row flushes the last image row out of the line buffer
	localparam int beatsPerFrame = imageWidth * (imageHeight + 1);

	// sample and position widths
	typedef logic [7:0] pixel_t;
	typedef logic [7:0] coord_t;
	typedef logic [15:0] beatCount_t;

	// statistics widths, 128 pixels of 255 fit in 16 bits
	typedef logic [15:0] channelSum_t;
	typedef logic [15:0] frameCount_t;

	// register port widths
	typedef logic [1:0] wbAddr_t;
	typedef logic [31:0] wbData_t;

	// raw mosaic stream, one pixel per valid beat
	typedef struct packed {
		logic valid;
		pixel_t data;
	} rawBeat_t;

	// full colour stream with position and end of frame
	typedef struct packed {
		logic valid;
		logic done;
		coord_t x;
		coord_t y;
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgbBeat_t;

	// wishbone master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wbAddr_t adr;
		wbData_t dat;
	} wbReq_t;

	// wishbone slave to master
	typedef struct packed {
		logic ack;
		wbData_t dat;
	} wbRsp_t;

	// register word addresses
	localparam wbAddr_t regFrameCount = 2'd0;
	localparam wbAddr_t regSumRed = 2'd1;
	localparam wbAddr_t regSumGreen = 2'd2;
	localparam wbAddr_t regSumBlue = 2'd3;

endpackage

// ==== hdl/lineBuffer.sv ====
module lineBuffer (
	input logic clk,
	input logic reset,
	input logic shiftEnable,
	input demosaicPkg::pixel_t shiftIn,
	output demosaicPkg::pixel_t rowTap
);

	localparam int depth = demosaicPkg::imageWidth;

	// stage 0 is the newest pixel, the last stage the oldest
	demosaicPkg::pixel_t stages [depth];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				stages[i] <= '0;
			end
		end else if (shiftEnable) begin
			stages[0] <= shiftIn;
			for (int i = 1; i < depth; i++) begin
				stages[i] <= stages[i - 1];
			end
		end
	end

	// pixel that entered one full row of valid beats ago
	assign rowTap = stages[depth - 1];

endmodule

// ==== hdl/bayerDemosaic.sv ====
module bayerDemosaic (
	input logic clk,
	input logic reset,
	input demosaicPkg::rawBeat_t pixelIn,
	input demosaicPkg::pixel_t rowTap,
	output demosaicPkg::rgbBeat_t pixelOut,
	output logic shiftEnable
);

	// beat position within the frame
	demosaicPkg::beatCount_t beatIndex;
	demosaicPkg::coord_t xPos;
	demosaicPkg::coord_t yPos;

	logic outputBeat;
	logic lastBeat;
	logic lastColumn;
	logic lastRow;

	// 2x2 window, U and L in this column, Up and Lp one column back
	demosaicPkg::pixel_t upperCur;
	demosaicPkg::pixel_t lowerCur;
	demosaicPkg::pixel_t upperPrev;
	demosaicPkg::pixel_t lowerPrev;
	demosaicPkg::pixel_t prevUpper;
	demosaicPkg::pixel_t prevLower;

	// green averages for the two diagonals
	logic [8:0] sumLowerPrevUpper;
	logic [8:0] sumLowerUpperPrev;

	demosaicPkg::pixel_t nextR;
	demosaicPkg::pixel_t nextG;
	demosaicPkg::pixel_t nextB;

	// registered output stream
	logic outValid;
	logic outDone;
	demosaicPkg::coord_t outX;
	demosaicPkg::coord_t outY;
	demosaicPkg::pixel_t outR;
	demosaicPkg::pixel_t outG;
	demosaicPkg::pixel_t outB;

	assign shiftEnable = pixelIn.valid;

	// the first row only fills the line buffer
	assign outputBeat = pixelIn.valid &&
		(beatIndex >= demosaicPkg::beatCount_t'(demosaicPkg::imageWidth));
	assign lastBeat = beatIndex == demosaicPkg::beatCount_t'(demosaicPkg::beatsPerFrame - 1);
	assign lastColumn = xPos == demosaicPkg::coord_t'(demosaicPkg::imageWidth - 1);
	assign lastRow = yPos == demosaicPkg::coord_t'(demosaicPkg::imageHeight - 1);

	// lower row on the last image row is the padding row
	assign upperCur = rowTap;
	assign lowerCur = lastRow ? '0 : pixelIn.data;

	// nothing left of column 0
	assign upperPrev = (xPos == '0) ? '0 : prevUpper;
	assign lowerPrev = (xPos == '0) ? '0 : prevLower;

	assign sumLowerPrevUpper = {1'b0, lowerPrev} + {1'b0, upperCur};
	assign sumLowerUpperPrev = {1'b0, lowerCur} + {1'b0, upperPrev};

	// rggb phase select
	always_comb begin
		case ({yPos[0], xPos[0]})
			2'b00: begin
				nextR = lowerCur;
				nextG = sumLowerPrevUpper[8:1];
				nextB = upperPrev;
			end
			2'b01: begin
				nextR = lowerPrev;
				nextG = sumLowerUpperPrev[8:1];
				nextB = upperCur;
			end
			2'b10: begin
				nextR = upperCur;
				nextG = sumLowerUpperPrev[8:1];
				nextB = lowerPrev;
			end
			default: begin
				nextR = upperPrev;
				nextG = sumLowerPrevUpper[8:1];
				nextB = lowerCur;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			beatIndex <= '0;
			xPos <= '0;
			yPos <= '0;
		end else if (pixelIn.valid) begin
			beatIndex <= lastBeat ? '0 : beatIndex + 1'b1;
			if (outputBeat) begin
				if (lastColumn) begin
					xPos <= '0;
					yPos <= lastRow ? '0 : yPos + 1'b1;
				end else begin
					xPos <= xPos + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			outDone <= 1'b0;
		end else begin
			outValid <= outputBeat;
			outDone <= outputBeat && lastBeat;
		end
	end

	always_ff @(posedge clk) begin
		if (pixelIn.valid) begin
			prevUpper <= upperCur;
			prevLower <= lowerCur;
		end
		if (outputBeat) begin
			outX <= xPos;
			outY <= yPos;
			outR <= nextR;
			outG <= nextG;
			outB <= nextB;
		end
	end

	assign pixelOut.valid = outValid;
	assign pixelOut.done = outDone;
	assign pixelOut.x = outX;
	assign pixelOut.y = outY;
	assign pixelOut.r = outR;
	assign pixelOut.g = outG;
	assign pixelOut.b = outB;

endmodule

// ==== hdl/frameStats.sv ====
module frameStats (
	input logic clk,
	input logic reset,
	input demosaicPkg::rgbBeat_t pixelIn,
	input logic clearFrames,
	output demosaicPkg::channelSum_t sumRed,
	output demosaicPkg::channelSum_t sumGreen,
	output demosaicPkg::channelSum_t sumBlue,
	output demosaicPkg::frameCount_t frameCount
);

	// running totals for the frame in progress
	demosaicPkg::channelSum_t accRed;
	demosaicPkg::channelSum_t accGreen;
	demosaicPkg::channelSum_t accBlue;

	// totals including the current beat
	demosaicPkg::channelSum_t totalRed;
	demosaicPkg::channelSum_t totalGreen;
	demosaicPkg::channelSum_t totalBlue;

	logic frameEnd;

	assign totalRed = accRed + demosaicPkg::channelSum_t'(pixelIn.r);
	assign totalGreen = accGreen + demosaicPkg::channelSum_t'(pixelIn.g);
	assign totalBlue = accBlue + demosaicPkg::channelSum_t'(pixelIn.b);

	assign frameEnd = pixelIn.valid && pixelIn.done;

	always_ff @(posedge clk) begin
		if (reset) begin
			accRed <= '0;
			accGreen <= '0;
			accBlue <= '0;
			sumRed <= '0;
			sumGreen <= '0;
			sumBlue <= '0;
		end else if (frameEnd) begin
			// snapshot includes the done pixel, then restart
			sumRed <= totalRed;
			sumGreen <= totalGreen;
			sumBlue <= totalBlue;
			accRed <= '0;
			accGreen <= '0;
			accBlue <= '0;
		end else if (pixelIn.valid) begin
			accRed <= totalRed;
			accGreen <= totalGreen;
			accBlue <= totalBlue;
		end
	end

	// host clear wins over a frame completing in the same cycle
	always_ff @(posedge clk) begin
		if (reset || clearFrames) begin
			frameCount <= '0;
		end else if (frameEnd) begin
			frameCount <= frameCount + 1'b1;
		end
	end

endmodule

// ==== hdl/statsCsr.sv ====
module statsCsr (
	input logic clk,
	input logic reset,
	input demosaicPkg::wbReq_t wbIn,
	output demosaicPkg::wbRsp_t wbOut,
	input demosaicPkg::channelSum_t sumRed,
	input demosaicPkg::channelSum_t sumGreen,
	input demosaicPkg::channelSum_t sumBlue,
	input demosaicPkg::frameCount_t frameCount,
	output logic clearFrames
);

	logic ackReg;
	logic request;
	demosaicPkg::wbData_t readData;

	// no new transfer in the ack cycle, so acks never come back to back
	assign request = wbIn.cyc && wbIn.stb && !ackReg;

	// write to the frame count register clears it on the edge raising ack
	assign clearFrames = request && wbIn.we &&
		(wbIn.adr == demosaicPkg::regFrameCount);

	always_ff @(posedge clk) begin
		if (reset) begin
			ackReg <= 1'b0;
		end else begin
			ackReg <= request;
		end
	end

	// read data is sampled with the request and held through ack
	always_ff @(posedge clk) begin
		if (request) begin
			case (wbIn.adr)
				demosaicPkg::regFrameCount: begin
					readData <= demosaicPkg::wbData_t'(frameCount);
				end
				demosaicPkg::regSumRed: begin
					readData <= demosaicPkg::wbData_t'(sumRed);
				end
				demosaicPkg::regSumGreen: begin
					readData <= demosaicPkg::wbData_t'(sumGreen);
				end
				default: begin
					readData <= demosaicPkg::wbData_t'(sumBlue);
				end
			endcase
		end
	end

	assign wbOut.ack = ackReg;
	assign wbOut.dat = readData;

endmodule

// ==== hdl/demosaicTop.sv ====
module demosaicTop (
	input logic clk,
	input logic reset,
	input demosaicPkg::rawBeat_t pixelIn,
	output demosaicPkg::rgbBeat_t pixelOut,
	input demosaicPkg::wbReq_t wbIn,
	output demosaicPkg::wbRsp_t wbOut
);

	// line buffer to demosaic
	logic shiftEnable;
	demosaicPkg::pixel_t rowTap;

	// statistics to register port
	demosaicPkg::channelSum_t sumRed;
	demosaicPkg::channelSum_t sumGreen;
	demosaicPkg::channelSum_t sumBlue;
	demosaicPkg::frameCount_t frameCount;
	logic clearFrames;

	lineBuffer lineBuffer_i (
		.clk(clk),
		.reset(reset),
		.shiftEnable(shiftEnable),
		.shiftIn(pixelIn.data),
		.rowTap(rowTap)
	);

	bayerDemosaic bayerDemosaic_i (
		.clk(clk),
		.reset(reset),
		.pixelIn(pixelIn),
		.rowTap(rowTap),
		.pixelOut(pixelOut),
		.shiftEnable(shiftEnable)
	);

	// watches the same stream that leaves the top
	frameStats frameStats_i (
		.clk(clk),
		.reset(reset),
		.pixelIn(pixelOut),
		.clearFrames(clearFrames),
		.sumRed(sumRed),
		.sumGreen(sumGreen),
		.sumBlue(sumBlue),
		.frameCount(frameCount)
	);

	statsCsr statsCsr_i (
		.clk(clk),
		.reset(reset),
		.wbIn(wbIn),
		.wbOut(wbOut),
		.sumRed(sumRed),
		.sumGreen(sumGreen),
		.sumBlue(sumBlue),
		.frameCount(frameCount),
		.clearFrames(clearFrames)
	);

endmodule

// ==== dv/demosaicTb_sva.sv ====
module demosaicCheck (
	input logic clk,
	input logic reset,
	input demosaicPkg::rgbBeat_t pixelOut,
	input demosaicPkg::wbReq_t wbIn,
	input demosaicPkg::wbRsp_t wbOut
);
	timeunit 1ns;
	timeprecision 100ps;

	// high once reset has been seen on two edges in a row
	logic resetSettled;

	always @(posedge clk) begin
		resetSettled <= reset;
	end

	ackSingleCycle: assert property (@(posedge clk) disable iff (reset)
		wbOut.ack |=> !wbOut.ack)
		else $error("register port ack stayed high for two cycles");

	ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
		wbOut.ack |-> $past(wbIn.cyc && wbIn.stb))
		else $error("register port ack without a request in the cycle before");

	doneWithValid: assert property (@(posedge clk) disable iff (reset)
		pixelOut.done |-> pixelOut.valid)
		else $error("done raised on a pixel that is not valid");

	quietInReset: assert property (@(posedge clk)
		(reset && resetSettled) |-> (!pixelOut.valid && !wbOut.ack))
		else $error("valid or ack high while reset is held");

endmodule

bind demosaicTop demosaicCheck demosaicCheck_i (
	.clk(clk),
	.reset(reset),
	.pixelOut(pixelOut),
	.wbIn(wbIn),
	.wbOut(wbOut)
);

// ==== dv/demosaicTb.sv ====
module demosaicTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int width = demosaicPkg::imageWidth;
	localparam int height = demosaicPkg::imageHeight;
	localparam int ackTimeout = 8;
	localparam int drainTimeout = 16;

	logic clk = 1'b0;
	logic reset;
	demosaicPkg::rawBeat_t pixelIn;
	demosaicPkg::rgbBeat_t pixelOut;
	demosaicPkg::wbReq_t wbIn;
	demosaicPkg::wbRsp_t wbOut;

	logic [31:0] lfsrState;
	logic outputPending;
	int mismatchCount;
	int failureCount;
	int validCount;
	int doneCount;

	// one frame of raw mosaic whose last row is padding
	demosaicPkg::pixel_t rawFrame [height + 1][width];
	demosaicPkg::rgbBeat_t expectQueue [$];
	demosaicPkg::channelSum_t modelRed;
	demosaicPkg::channelSum_t modelGreen;
	demosaicPkg::channelSum_t modelBlue;
	demosaicPkg::frameCount_t modelFrames;
	string regNames [4] = '{"regFrameCount", "regSumRed", "regSumGreen", "regSumBlue"};

	demosaicTop dut_i (
		.clk(clk),
		.reset(reset),
		.pixelIn(pixelIn),
		.pixelOut(pixelOut),
		.wbIn(wbIn),
		.wbOut(wbOut)
	);

	always #50 clk = ~clk;

	// taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] drawBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
			mismatchCount++;
		end
	endtask

	// nearest neighbor colours of pixel (x, y) from the rggb table
	function automatic demosaicPkg::rgbBeat_t modelPixel(input int x, input int y);
		demosaicPkg::rgbBeat_t pixel;
		demosaicPkg::pixel_t u;
		demosaicPkg::pixel_t l;
		demosaicPkg::pixel_t up;
		demosaicPkg::pixel_t lp;
		logic [8:0] lpPlusU;
		logic [8:0] lPlusUp;
		u = rawFrame[y][x];
		l = (y == height - 1) ? 8'd0 : rawFrame[y + 1][x];
		up = (x == 0) ? 8'd0 : rawFrame[y][x - 1];
		lp = (x == 0 || y == height - 1) ? 8'd0 : rawFrame[y + 1][x - 1];
		lpPlusU = {1'b0, lp} + {1'b0, u};
		lPlusUp = {1'b0, l} + {1'b0, up};
		pixel.valid = 1'b1;
		pixel.done = (x == width - 1) && (y == height - 1);
		pixel.x = demosaicPkg::coord_t'(x);
		pixel.y = demosaicPkg::coord_t'(y);
		if (y % 2 == 0 && x % 2 == 0) begin
			pixel.r = l;
			pixel.g = lpPlusU[8:1];
			pixel.b = up;
		end else if (y % 2 == 0) begin
			pixel.r = lp;
			pixel.g = lPlusUp[8:1];
			pixel.b = u;
		end else if (x % 2 == 0) begin
			pixel.r = u;
			pixel.g = lPlusUp[8:1];
			pixel.b = lp;
		end else begin
			pixel.r = up;
			pixel.g = lpPlusU[8:1];
			pixel.b = l;
		end
		return pixel;
	endfunction

	// outputs seen at this falling edge belong to the beat driven one cycle earlier
	task automatic driveCycle(input logic valid, input demosaicPkg::pixel_t data,
			input logic producesOutput);
		demosaicPkg::rgbBeat_t expected;
		@(negedge clk);
		checkValue("pixelOut.valid", 32'(pixelOut.valid), 32'(outputPending));
		if (pixelOut.valid && expectQueue.size() == 0) begin
			$display("an output pixel appeared at %0d ns with none left to match", $time);
			failureCount++;
		end else if (pixelOut.valid) begin
			expected = expectQueue.pop_front();
			checkValue("pixelOut.x", 32'(pixelOut.x), 32'(expected.x));
			checkValue("pixelOut.y", 32'(pixelOut.y), 32'(expected.y));
			checkValue("pixelOut.r", 32'(pixelOut.r), 32'(expected.r));
			checkValue("pixelOut.g", 32'(pixelOut.g), 32'(expected.g));
			checkValue("pixelOut.b", 32'(pixelOut.b), 32'(expected.b));
			checkValue("pixelOut.done", 32'(pixelOut.done), 32'(expected.done));
			validCount++;
			doneCount += int'(pixelOut.done);
		end
		pixelIn.valid = valid;
		pixelIn.data = data;
		outputPending = producesOutput;
	endtask

	task automatic wbTransfer(input demosaicPkg::wbAddr_t addr, input logic write,
			input demosaicPkg::wbData_t writeData, output demosaicPkg::wbData_t readData);
		int waitCycles;
		@(negedge clk);
		wbIn.cyc = 1'b1;
		wbIn.stb = 1'b1;
		wbIn.we = write;
		wbIn.adr = addr;
		wbIn.dat = writeData;
		waitCycles = 0;
		readData = '0;
		do begin
			@(negedge clk);
			waitCycles++;
		end while (!wbOut.ack && waitCycles < ackTimeout);
		if (wbOut.ack) begin
			readData = wbOut.dat;
		end else begin
			$display("the register port gave no ack within %0d cycles at %0d ns", ackTimeout, $time);
			failureCount++;
		end
		wbIn = '0;
	endtask

	task automatic checkRegisters(input demosaicPkg::frameCount_t count);
		demosaicPkg::wbData_t expected [4];
		demosaicPkg::wbData_t data;
		demosaicPkg::wbAddr_t addr;
		expected[demosaicPkg::regFrameCount] = 32'(count);
		expected[demosaicPkg::regSumRed] = 32'(modelRed);
		expected[demosaicPkg::regSumGreen] = 32'(modelGreen);
		expected[demosaicPkg::regSumBlue] = 32'(modelBlue);
		// random first register, then the rest in turn
		addr = demosaicPkg::wbAddr_t'(drawBits(2));
		repeat (4) begin
			wbTransfer(addr, 1'b0, '0, data);
			checkValue(regNames[addr], data, expected[addr]);
			addr = addr + 1'b1;
		end
	endtask

	task automatic runFrame();
		demosaicPkg::rgbBeat_t expected;
		int waitCycles;
		modelRed = '0;
		modelGreen = '0;
		modelBlue = '0;
		validCount = 0;
		doneCount = 0;
		for (int row = 0; row <= height; row++) begin
			for (int column = 0; column < width; column++) begin
				rawFrame[row][column] = demosaicPkg::pixel_t'(drawBits(8));
			end
		end
		for (int row = 0; row < height; row++) begin
			for (int column = 0; column < width; column++) begin
				expected = modelPixel(column, row);
				expectQueue.push_back(expected);
				modelRed = modelRed + demosaicPkg::channelSum_t'(expected.r);
				modelGreen = modelGreen + demosaicPkg::channelSum_t'(expected.g);
				modelBlue = modelBlue + demosaicPkg::channelSum_t'(expected.b);
			end
		end
		for (int beat = 0; beat < demosaicPkg::beatsPerFrame; beat++) begin
			// both gap bits zero holds valid low for one cycle
			if (drawBits(2) == 0) begin
				driveCycle(1'b0, '0, 1'b0);
			end
			driveCycle(1'b1, rawFrame[beat / width][beat % width], beat >= width);
		end
		waitCycles = 0;
		while (expectQueue.size() != 0 && waitCycles < drainTimeout) begin
			driveCycle(1'b0, '0, 1'b0);
			waitCycles++;
		end
		if (expectQueue.size() != 0) begin
			$display("%0d output pixels never appeared by %0d ns", expectQueue.size(), $time);
			failureCount++;
			expectQueue.delete();
		end
		checkValue("valid pixels per frame", validCount, width * height);
		checkValue("done pulses per frame", doneCount, 1);
	endtask

	initial begin
		demosaicPkg::wbData_t readBack;
		lfsrState = 32'h9123;
		reset = 1'b1;
		pixelIn = '0;
		wbIn = '0;
		outputPending = 1'b0;
		mismatchCount = 0;
		failureCount = 0;
		modelRed = '0;
		modelGreen = '0;
		modelBlue = '0;
		modelFrames = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// idle outputs and cleared registers right after reset
		driveCycle(1'b0, '0, 1'b0);
		checkValue("pixelOut.done", 32'(pixelOut.done), 32'(0));
		checkRegisters(modelFrames);
		repeat (3) begin
			runFrame();
			modelFrames = modelFrames + 1'b1;
			checkRegisters(modelFrames);
		end
		// sum addresses are read only and leave the frame count alone
		wbTransfer(demosaicPkg::regSumRed, 1'b1, drawBits(32), readBack);
		wbTransfer(demosaicPkg::regSumGreen, 1'b1, drawBits(32), readBack);
		wbTransfer(demosaicPkg::regSumBlue, 1'b1, drawBits(32), readBack);
		checkRegisters(modelFrames);
		// a frame count write clears only the count
		wbTransfer(demosaicPkg::regFrameCount, 1'b1, drawBits(32), readBack);
		modelFrames = '0;
		checkRegisters(modelFrames);
		runFrame();
		modelFrames = modelFrames + 1'b1;
		checkRegisters(modelFrames);
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/demosaicPkg.sv
hdl/lineBuffer.sv
hdl/bayerDemosaic.sv
hdl/frameStats.sv
hdl/statsCsr.sv
hdl/demosaicTop.sv
dv/demosaicTb_sva.sv
dv/demosaicTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module demosaicTb -f tb.f -o demosaicSim
./obj_dir/demosaicSim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi

echo "simulation finished without failure"
